/* xm23_dev_top.f */
+incdir+.
xm23_dev_pkg.sv
xm23_dev_regs.sv
xm23_timer.sv
xm23_traffic_lights.sv
xm23_pedest_button.sv
xm23_dev_top.sv
xm23_dev_assertions.sv
xm23_dev_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= xm23_dev_tb
RTL_TOP   ?= xm23_dev_top
FILELIST  ?= xm23_dev_top.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* xm23_dev_tb.sv */
`timescale 1ns/100ps
`include "xm23_dev_defines.svh"

module xm23_dev_tb;
	import xm23_dev_pkg::*;

	localparam int T_TMR = 6 * 4 * `XM23_TMR_PRESCALE + 200;
	localparam int T_TL = 4 * 8 * 8 * `XM23_TMR_PRESCALE + 200;
	localparam int T_PB = 8 * `XM23_PB_DEBOUNCE + 600;
	localparam int LIMIT = 10 + 300 + T_TMR + T_TL + T_PB + 1000;	// Clocks, with margin

	logic      clk;
	logic      rst_n;
	logic      cyc;
	logic      stb;
	logic      we;
	dev_addr_t adr;
	dev_byte_t wdat;
	dev_byte_t rdat;
	logic      ack;
	logic      button;
	lights_t   lights;
	logic [2:0] irq;
	logic [31:0] rnd_state = 32'hdb803c3d;
	int        errors = 0;
	int        tests = 0;
	int        mark;
	dev_byte_t v;
	dev_byte_t v2;
	dev_byte_t rdat_tmp;
	int        t_ticks;

	xm23_dev_top xm23_dev_top_i (
		.clk_i (clk), .rst_n_i (rst_n), .wb_cyc_i (cyc), .wb_stb_i (stb), .wb_we_i (we),
		.wb_adr_i (adr), .wb_dat_i (wdat), .wb_dat_o (rdat), .wb_ack_o (ack),
		.push_button_i (button), .lights_o (lights), .irq_o (irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int total_errors();
		return errors + xm23_dev_top_i.xm23_dev_assertions_i.fail_cnt;
	endfunction

	function automatic dev_byte_t lcg_next();
		rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
		return rnd_state[23:16];
	endfunction

	task automatic check_byte(input string name, input dev_byte_t got, input dev_byte_t exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s got %02h expected %02h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		@(negedge clk);
		while (!ack && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (!ack) begin
			$display("Error at %0t: no bus ack", $time);
			errors++;
		end
	endtask

	task automatic bus_write(input dev_addr_t a, input dev_byte_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= a;
		wdat <= d;
		wait_ack();
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic bus_read(input dev_addr_t a, output dev_byte_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= a;
		wait_ack();
		d = rdat;	// Stable while ack is high
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	task automatic wait_lights(input string what, input int limit, input lights_t mask,
		input lights_t val);
		int n;
		n = 0;
		@(negedge clk);
		while ((lights & mask) != val && n < limit) begin
			@(negedge clk);
			n++;
		end
		if ((lights & mask) != val) begin
			$display("Error at %0t: timed out waiting for %s", $time, what);
			errors++;
		end
	endtask

	task automatic wait_irq(input int idx, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!irq[idx] && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!irq[idx]) begin
			$display("Error at %0t: timed out waiting for irq_o[%0d]", $time, idx);
			errors++;
		end
	endtask

	task automatic hold_button(input logic level, input int clocks);
		@(posedge clk);
		button <= level;
		repeat (clocks) @(posedge clk);
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s %s", tests, name, (total_errors() == mark) ? "ok" : "FAILED");
		mark = total_errors();
	endtask

	// Watchdog
	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("Error: run did not finish within %0d clocks", LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		wdat = '0;
		button = 1'b0;
		mark = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_byte("wb_ack_o", {7'd0, ack}, 8'h00);
		check_byte("irq_o", {5'd0, irq}, 8'h00);
		check_byte("lights_o", {4'd0, lights}, 8'h00);
		bus_read(`XM23_TMR_CSR, v);
		check_byte("tmr_csr", v, 8'h00);
		report_test("reset_bus");

		v = lcg_next();
		v2 = lcg_next();
		bus_write(`XM23_TMR_DATA, v);
		bus_write(`XM23_TL_DATA, v2);
		bus_write(`XM23_PB_DATA, 8'h5a);
		bus_write(4'h3, 8'ha5);
		bus_write(4'hf, 8'hff);
		bus_read(`XM23_TMR_DATA, rdat_tmp);
		check_byte("tmr_data", rdat_tmp, v);
		bus_read(`XM23_TL_DATA, rdat_tmp);
		check_byte("tl_data", rdat_tmp, v2);
		bus_read(`XM23_PB_DATA, rdat_tmp);
		check_byte("pb_data", rdat_tmp, 8'h00);
		bus_read(4'h3, rdat_tmp);
		check_byte("addr_3", rdat_tmp, 8'h00);
		bus_read(4'hf, rdat_tmp);
		check_byte("addr_f", rdat_tmp, 8'h00);
		report_test("data_regs");

		v = lcg_next() % 8'd4;
		t_ticks = (int'(v) + 1) * `XM23_TMR_PRESCALE;
		bus_write(`XM23_TMR_DATA, v);
		bus_write(`XM23_TMR_CSR, 8'h03);	// Enable with interrupt
		wait_irq(0, 2 * t_ticks);
		bus_read(`XM23_TMR_CSR, rdat_tmp);
		check_byte("tmr_csr[3:0]", rdat_tmp & 8'h0f, 8'h07);
		bus_read(`XM23_TMR_CSR, rdat_tmp);
		check_byte("tmr_csr[3:0]", rdat_tmp & 8'h0f, 8'h03);
		repeat (2 * t_ticks + 2) @(posedge clk);
		bus_read(`XM23_TMR_CSR, rdat_tmp);
		check_byte("tmr_csr[3:0]", rdat_tmp & 8'h0f, 8'h0f);
		bus_write(`XM23_TMR_CSR, 8'h00);
		report_test("timer");

		v = lcg_next() % 8'd3;	// Green ticks minus one
		v2 = lcg_next() % 8'd3;	// Red ticks minus one
		v = {v[3:0], v2[3:0]};
		bus_write(`XM23_TL_DATA, v);
		bus_write(`XM23_TL_CSR, 8'h03);
		wait_lights("green", 200, 4'h7, 4'h1);
		wait_lights("red", 400, 4'h7, 4'h4);
		wait_lights("green again", 400, 4'h7, 4'h1);
		wait_lights("amber", 400, 4'h7, 4'h2);
		check_byte("irq_o[1]", {7'd0, irq[1]}, 8'h01);	// One full cycle done
		report_test("lights");

		bus_write(`XM23_PB_CSR, 8'h03);
		hold_button(1'b1, 1 + lcg_next() % 8'd12);	// Bounce
		hold_button(1'b0, 2 * `XM23_PB_DEBOUNCE);
		bus_read(`XM23_PB_DATA, rdat_tmp);
		check_byte("pb_data", rdat_tmp, 8'h00);
		hold_button(1'b1, `XM23_PB_DEBOUNCE + 3);	// Press strobe has just gone out
		wait_lights("walk", 600, 4'hc, 4'hc);
		check_byte("irq_o[2]", {7'd0, irq[2]}, 8'h01);
		hold_button(1'b0, 2 * `XM23_PB_DEBOUNCE);
		bus_read(`XM23_PB_DATA, rdat_tmp);
		check_byte("pb_data", rdat_tmp, 8'h01);
		bus_read(`XM23_PB_CSR, rdat_tmp);
		check_byte("pb_csr.dba", rdat_tmp & 8'h04, 8'h04);
		report_test("button");

		$display("tests %0d, testbench errors %0d, assertion failures %0d", tests, errors,
			xm23_dev_top_i.xm23_dev_assertions_i.fail_cnt);
		if (total_errors() == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* xm23_dev_assertions.sv */
`timescale 1ns/100ps
`include "xm23_dev_defines.svh"

module xm23_dev_assertions (
	input logic                    clk_i,
	input logic                    rst_n_i,
	input logic                    wb_cyc_i,
	input logic                    wb_stb_i,
	input logic                    wb_we_i,
	input xm23_dev_pkg::dev_addr_t wb_adr_i,
	input xm23_dev_pkg::dev_byte_t wb_dat_i,
	input xm23_dev_pkg::dev_byte_t wb_dat_o,
	input logic                    wb_ack_i,
	input logic                    button_i,
	input xm23_dev_pkg::lights_t   lights_i,
	input logic [2:0]              irq_i,
	input xm23_dev_pkg::dev_byte_t tmr_csr_i,
	input xm23_dev_pkg::dev_byte_t tmr_data_i,
	input xm23_dev_pkg::dev_byte_t tl_data_i,
	input xm23_dev_pkg::dev_byte_t pb_count_i,
	input xm23_dev_pkg::dev_evt_t  tmr_evt_i,
	input logic                    tick_i,
	input logic                    press_i
);
	import xm23_dev_pkg::*;

	int        fail_cnt = 0;	// Failed checks so far
	logic      req;
	logic      tmr_csr_req;
	dev_byte_t shadow_tmr_data;
	dev_byte_t shadow_tl_data;
	int        gap;	// Clocks since timer enable or last event
	logic      tmr_en_d;
	int        tick_cnt;	// Ticks seen in the current light phase
	logic [2:0] lamp_d;
	logic      walk_d;
	logic      ped_seen;
	int        hi_run;	// Clocks the raw button has been high

	function automatic int phase_ticks(input logic [2:0] lamp, input dev_byte_t d);
		case (lamp)
			3'b001:  return int'(d[7:4]) + 1;
			3'b010:  return `XM23_TL_AMBER_TICKS;
			default: return int'(d[3:0]) + 1;
		endcase
	endfunction

	assign req = wb_cyc_i & wb_stb_i & ~wb_ack_i;
	assign tmr_csr_req = req && (wb_adr_i == `XM23_TMR_CSR);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gap <= 0;
			tmr_en_d <= 1'b0;
			tick_cnt <= 0;
			lamp_d <= '0;
			walk_d <= 1'b0;
			ped_seen <= 1'b0;
			hi_run <= 0;
		end else begin
			tmr_en_d <= tmr_csr_i[`XM23_CSR_EN];
			gap <= (tmr_evt_i.evt || !tmr_en_d) ? 1 : gap + 1;
			lamp_d <= lights_i[2:0];
			walk_d <= lights_i[3];
			if (lights_i[2:0] != lamp_d)
				tick_cnt <= 0;
			else if (tick_i)
				tick_cnt <= tick_cnt + 1;
			if (press_i)
				ped_seen <= 1'b1;
			else if (lights_i[3] && !walk_d)
				ped_seen <= 1'b0;	// Request used up
			hi_run <= button_i ? hi_run + 1 : 0;
			if (req && wb_we_i && wb_adr_i == `XM23_TMR_DATA)
				shadow_tmr_data <= wb_dat_i;
			if (req && wb_we_i && wb_adr_i == `XM23_TL_DATA)
				shadow_tl_data <= wb_dat_i;
		end
	end

	// Bus handshake
	a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
		else begin $error("ack without request"); fail_cnt++; end
	a_ack_one: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		req |=> wb_ack_i ##1 !wb_ack_i)
		else begin $error("ack timing wrong"); fail_cnt++; end
	a_rd_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i && !wb_we_i && wb_adr_i == `XM23_TMR_DATA |-> wb_dat_o == shadow_tmr_data)
		else begin $error("timer data readback"); fail_cnt++; end
	a_rd_tl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i && !wb_we_i && wb_adr_i == `XM23_TL_DATA |-> wb_dat_o == shadow_tl_data)
		else begin $error("lights data readback"); fail_cnt++; end
	a_rd_hole: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i && !wb_we_i && wb_adr_i inside {[4'h2:4'h5], [4'ha:4'hf]} |-> wb_dat_o == '0)
		else begin $error("unmapped address not zero"); fail_cnt++; end

	// Timer events and CSR rules
	a_tmr_gap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tmr_evt_i.evt |-> gap == (int'(tmr_data_i) + 1) * `XM23_TMR_PRESCALE)
		else begin $error("timer interval wrong"); fail_cnt++; end
	a_tmr_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tmr_evt_i.evt && tmr_csr_i[`XM23_CSR_IE] && !tmr_csr_req |=> irq_i[0])
		else begin $error("timer irq missing"); fail_cnt++; end
	a_tmr_of: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tmr_evt_i.evt && tmr_csr_i[`XM23_CSR_DBA] && !tmr_csr_req |=> tmr_csr_i[`XM23_CSR_OF])
		else begin $error("overflow not set"); fail_cnt++; end
	a_tmr_clr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tmr_csr_req && !wb_we_i && !tmr_evt_i.evt
		|=> !tmr_csr_i[`XM23_CSR_DBA] && !tmr_csr_i[`XM23_CSR_OF])
		else begin $error("CSR read did not clear"); fail_cnt++; end

	// Traffic lights
	a_tl_one: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0(lights_i[2:0]) && (!lights_i[3] || lights_i[2]))
		else begin $error("illegal lamp pattern"); fail_cnt++; end
	a_tl_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lamp_d != 0 && lights_i[2:0] != 0 && lights_i[2:0] != lamp_d
		|-> lights_i[2:0] == {lamp_d[1:0], lamp_d[2]}
		&& tick_cnt == phase_ticks(lamp_d, tl_data_i))
		else begin $error("light order or length wrong"); fail_cnt++; end
	a_tl_walk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lights_i[3] && !walk_d |-> ped_seen)
		else begin $error("walk without press"); fail_cnt++; end

	// Push button
	a_pb_clean: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		press_i |-> hi_run == `XM23_PB_DEBOUNCE + 2)
		else begin $error("press not debounced"); fail_cnt++; end
	a_pb_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$changed(pb_count_i) |-> pb_count_i == $past(pb_count_i) + 8'd1)
		else begin $error("press count step wrong"); fail_cnt++; end

endmodule

bind xm23_dev_top xm23_dev_assertions xm23_dev_assertions_i (
	.clk_i (clk_i), .rst_n_i (rst_n_i), .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
	.wb_we_i (wb_we_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o),
	.wb_ack_i (wb_ack_o), .button_i (push_button_i), .lights_i (lights_o), .irq_i (irq_o),
	.tmr_csr_i (tmr_csr), .tmr_data_i (tmr_data), .tl_data_i (tl_data),
	.pb_count_i (pb_count), .tmr_evt_i (tmr_evt), .tick_i (tmr_tick), .press_i (pb_press)
);

/* xm23_dev_top.sv */
`timescale 1ns/100ps

module xm23_dev_top (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  xm23_dev_pkg::dev_addr_t wb_adr_i,
	input  xm23_dev_pkg::dev_byte_t wb_dat_i,
	output xm23_dev_pkg::dev_byte_t wb_dat_o,
	output logic                    wb_ack_o,
	input  logic                    push_button_i,
	output xm23_dev_pkg::lights_t   lights_o,
	output logic [2:0]              irq_o
);
	import xm23_dev_pkg::*;

	dev_byte_t tmr_csr;
	dev_byte_t tmr_data;
	dev_byte_t tl_csr;
	dev_byte_t tl_data;
	dev_byte_t pb_csr;
	dev_byte_t pb_count;
	dev_evt_t  tmr_evt;
	dev_evt_t  tl_evt;
	dev_evt_t  pb_evt;
	logic      tmr_tick;	// Shared timebase for the lights
	logic      pb_press;

	xm23_dev_regs xm23_dev_regs_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.tmr_evt_i  (tmr_evt),
		.tl_evt_i   (tl_evt),
		.pb_evt_i   (pb_evt),
		.pb_count_i (pb_count),
		.tmr_csr_o  (tmr_csr),
		.tmr_data_o (tmr_data),
		.tl_csr_o   (tl_csr),
		.tl_data_o  (tl_data),
		.pb_csr_o   (pb_csr),
		.irq_o      (irq_o)
	);

	xm23_timer xm23_timer_i (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.csr_i   (tmr_csr),
		.data_i  (tmr_data),
		.tick_o  (tmr_tick),
		.evt_o   (tmr_evt)
	);

	xm23_traffic_lights xm23_traffic_lights_i (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.csr_i     (tl_csr),
		.data_i    (tl_data),
		.tick_i    (tmr_tick),
		.ped_req_i (pb_press),
		.lights_o  (lights_o),
		.evt_o     (tl_evt)
	);

	xm23_pedest_button xm23_pedest_button_i (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.csr_i    (pb_csr),
		.button_i (push_button_i),
		.press_o  (pb_press),
		.count_o  (pb_count),
		.evt_o    (pb_evt)
	);

endmodule

/* xm23_pedest_button.sv */
`timescale 1ns/100ps
`include "xm23_dev_defines.svh"

module xm23_pedest_button (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  xm23_dev_pkg::dev_byte_t csr_i,
	input  logic                    button_i,
	output logic                    press_o,
	output xm23_dev_pkg::dev_byte_t count_o,
	output xm23_dev_pkg::dev_evt_t  evt_o
);
	import xm23_dev_pkg::*;

	localparam int unsigned STAB_W = $clog2(`XM23_PB_DEBOUNCE + 1);

	logic [1:0]        sync_q;	// Metastability guard
	logic              level_q;	// Debounced level
	logic [STAB_W-1:0] stab_q;	// Clocks the new level has held
	logic              press_q;
	dev_byte_t         count_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q <= '0;
			level_q <= 1'b0;
			stab_q <= '0;
			press_q <= 1'b0;
			count_q <= '0;
		end else begin
			sync_q <= {sync_q[0], button_i};
			press_q <= 1'b0;
			if (sync_q[1] == level_q) begin
				stab_q <= '0;	// Bounce, start over
			end else if (stab_q == STAB_W'(`XM23_PB_DEBOUNCE - 1)) begin
				stab_q <= '0;
				level_q <= sync_q[1];
				// Count rising edges only while enabled
				if (sync_q[1] && csr_i[`XM23_CSR_EN]) begin
					press_q <= 1'b1;
					count_q <= count_q + 1'b1;	// Wraps at 256
				end
			end else begin
				stab_q <= stab_q + 1'b1;
			end
		end
	end

	assign press_o = press_q;
	assign count_o = count_q;
	assign evt_o.evt = press_q;
	assign evt_o.status = {level_q, count_q[2:0]};

endmodule

/* xm23_traffic_lights.sv */
`timescale 1ns/100ps
`include "xm23_dev_defines.svh"

module xm23_traffic_lights (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  xm23_dev_pkg::dev_byte_t csr_i,
	input  xm23_dev_pkg::dev_byte_t data_i,
	input  logic                    tick_i,
	input  logic                    ped_req_i,
	output xm23_dev_pkg::lights_t   lights_o,
	output xm23_dev_pkg::dev_evt_t  evt_o
);
	import xm23_dev_pkg::*;

	tl_state_t  state_q;
	logic [3:0] phase_q;	// Ticks left in this phase
	logic       ped_q;	// Walk request waiting
	logic       evt_q;
	logic       en;
	logic       last_tick;

	assign en = csr_i[`XM23_CSR_EN];
	assign last_tick = tick_i && (phase_q == 4'd0);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= TL_OFF;
			phase_q <= '0;
			ped_q <= 1'b0;
			evt_q <= 1'b0;
		end else begin
			evt_q <= 1'b0;
			if (!en) begin
				state_q <= TL_OFF;	// Dark at once
				phase_q <= '0;
				ped_q <= 1'b0;
			end else begin
				if (tick_i && phase_q != 4'd0)
					phase_q <= phase_q - 1'b1;
				// Phase changes only on a tick
				if (last_tick) begin
					case (state_q)
						TL_OFF, TL_RED, TL_WALK: begin
							state_q <= TL_GREEN;
							phase_q <= data_i[7:4];
							evt_q <= (state_q != TL_OFF);	// Full cycle done
						end
						TL_GREEN: begin
							state_q <= TL_AMBER;
							phase_q <= 4'(`XM23_TL_AMBER_TICKS - 1);
						end
						TL_AMBER: begin
							state_q <= ped_q ? TL_WALK : TL_RED;
							phase_q <= data_i[3:0];
							ped_q <= 1'b0;	// Request served or none pending
						end
						default: state_q <= TL_OFF;
					endcase
				end
				// A new press always sticks, even on the serving edge
				if (ped_req_i)
					ped_q <= 1'b1;
			end
		end
	end

	always_comb begin
		case (state_q)
			TL_GREEN: lights_o = 4'b0001;
			TL_AMBER: lights_o = 4'b0010;
			TL_RED:   lights_o = 4'b0100;
			TL_WALK:  lights_o = 4'b1100;	// Red plus walk
			default:  lights_o = 4'b0000;
		endcase
	end

	assign evt_o.evt = evt_q;
	assign evt_o.status = {ped_q, state_q};

endmodule

/* xm23_timer.sv */
`timescale 1ns/100ps
`include "xm23_dev_defines.svh"

module xm23_timer (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  xm23_dev_pkg::dev_byte_t csr_i,
	input  xm23_dev_pkg::dev_byte_t data_i,
	output logic                    tick_o,
	output xm23_dev_pkg::dev_evt_t  evt_o
);
	import xm23_dev_pkg::*;

	localparam int unsigned PRE_W = $clog2(`XM23_TMR_PRESCALE + 1);

	logic [PRE_W-1:0] pre_q;	// Prescaler phase
	logic             en;
	logic             en_q;
	logic             en_rise;
	logic             cnt_tick;
	dev_byte_t        cnt_q;	// Ticks left before the next event
	logic             evt_q;

	assign en = csr_i[`XM23_CSR_EN];
	assign en_rise = en & ~en_q;
	assign tick_o = (pre_q == PRE_W'(`XM23_TMR_PRESCALE - 1));
	assign cnt_tick = tick_o & ~en_rise;	// Counter starts fresh on enable

	// Free-running prescaler, realigned when the timer is switched on
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pre_q <= '0;
		end else if (en_rise) begin
			pre_q <= PRE_W'(1 % `XM23_TMR_PRESCALE);
		end else if (tick_o) begin
			pre_q <= '0;
		end else begin
			pre_q <= pre_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			en_q <= 1'b0;
			cnt_q <= '0;
			evt_q <= 1'b0;
		end else begin
			en_q <= en;
			evt_q <= 1'b0;
			if (!en) begin
				cnt_q <= data_i;	// Held at reload while off
			end else if (cnt_tick) begin
				if (cnt_q == '0) begin	// Wrap
					cnt_q <= data_i;
					evt_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
		end
	end

	assign evt_o.evt = evt_q;
	assign evt_o.status = cnt_q[3:0];

endmodule

/* xm23_dev_regs.sv */
`timescale 1ns/100ps
`include "xm23_dev_defines.svh"

module xm23_dev_regs (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  xm23_dev_pkg::dev_addr_t wb_adr_i,
	input  xm23_dev_pkg::dev_byte_t wb_dat_i,
	output xm23_dev_pkg::dev_byte_t wb_dat_o,
	output logic                    wb_ack_o,
	input  xm23_dev_pkg::dev_evt_t  tmr_evt_i,
	input  xm23_dev_pkg::dev_evt_t  tl_evt_i,
	input  xm23_dev_pkg::dev_evt_t  pb_evt_i,
	input  xm23_dev_pkg::dev_byte_t pb_count_i,
	output xm23_dev_pkg::dev_byte_t tmr_csr_o,
	output xm23_dev_pkg::dev_byte_t tmr_data_o,
	output xm23_dev_pkg::dev_byte_t tl_csr_o,
	output xm23_dev_pkg::dev_byte_t tl_data_o,
	output xm23_dev_pkg::dev_byte_t pb_csr_o,
	output logic [2:0]              irq_o
);
	import xm23_dev_pkg::*;

	logic      bus_req;	// New access this cycle
	logic      bus_wr;
	logic      bus_rd;
	logic      sel_tmr_csr;
	logic      sel_tmr_data;
	logic      sel_tl_csr;
	logic      sel_tl_data;
	logic      sel_pb_csr;
	dev_byte_t rd_mux;

	// Device memory
	dev_byte_t tmr_csr_q;
	dev_byte_t tl_csr_q;
	dev_byte_t pb_csr_q;
	dev_byte_t tmr_data_q;
	dev_byte_t tl_data_q;

	// Next CSR value from bus write, read-clear and device event
	function automatic dev_byte_t csr_next(
		input dev_byte_t cur,
		input dev_evt_t  evt,
		input logic      wr,
		input logic      rd,
		input dev_byte_t wdat
	);
		dev_byte_t nxt;
		nxt = cur;
		if (wr)
			nxt[`XM23_CSR_OF:`XM23_CSR_EN] = wdat[`XM23_CSR_OF:`XM23_CSR_EN];
		if (rd) begin	// Reading the CSR consumes the data
			nxt[`XM23_CSR_DBA] = 1'b0;
			nxt[`XM23_CSR_OF] = 1'b0;
		end
		// Event beats a read in the same cycle
		if (evt.evt) begin
			nxt[`XM23_CSR_OF] = nxt[`XM23_CSR_OF] | nxt[`XM23_CSR_DBA];	// Unread data lost
			nxt[`XM23_CSR_DBA] = 1'b1;
		end
		nxt[7:4] = evt.status;
		return nxt;
	endfunction

	// Classic single cycle ack, no retrigger while ack is up
	assign bus_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign bus_wr = bus_req & wb_we_i;
	assign bus_rd = bus_req & ~wb_we_i;

	assign sel_tmr_csr = (wb_adr_i == `XM23_TMR_CSR);
	assign sel_tmr_data = (wb_adr_i == `XM23_TMR_DATA);
	assign sel_tl_csr = (wb_adr_i == `XM23_TL_CSR);
	assign sel_tl_data = (wb_adr_i == `XM23_TL_DATA);
	assign sel_pb_csr = (wb_adr_i == `XM23_PB_CSR);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= bus_req;
		end
	end

	// Read mux, holes in the map read back zero
	always_comb begin
		case (wb_adr_i)
			`XM23_TMR_CSR:  rd_mux = tmr_csr_q;
			`XM23_TMR_DATA: rd_mux = tmr_data_q;
			`XM23_TL_CSR:   rd_mux = tl_csr_q;
			`XM23_TL_DATA:  rd_mux = tl_data_q;
			`XM23_PB_CSR:   rd_mux = pb_csr_q;
			`XM23_PB_DATA:  rd_mux = pb_count_i;	// Live press count
			default:        rd_mux = '0;
		endcase
	end

	// Read data sits in the ack cycle
	always_ff @(posedge clk_i) begin
		if (bus_rd)
			wb_dat_o <= rd_mux;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tmr_csr_q <= '0;
			tl_csr_q <= '0;
			pb_csr_q <= '0;
		end else begin
			tmr_csr_q <= csr_next(tmr_csr_q, tmr_evt_i, bus_wr & sel_tmr_csr,
				bus_rd & sel_tmr_csr, wb_dat_i);
			tl_csr_q <= csr_next(tl_csr_q, tl_evt_i, bus_wr & sel_tl_csr,
				bus_rd & sel_tl_csr, wb_dat_i);
			pb_csr_q <= csr_next(pb_csr_q, pb_evt_i, bus_wr & sel_pb_csr,
				bus_rd & sel_pb_csr, wb_dat_i);
		end
	end

	// Data bytes, written by the bus only
	always_ff @(posedge clk_i) begin
		if (bus_wr && sel_tmr_data)
			tmr_data_q <= wb_dat_i;
		if (bus_wr && sel_tl_data)
			tl_data_q <= wb_dat_i;
	end

	assign tmr_csr_o = tmr_csr_q;
	assign tmr_data_o = tmr_data_q;
	assign tl_csr_o = tl_csr_q;
	assign tl_data_o = tl_data_q;
	assign pb_csr_o = pb_csr_q;

	// One interrupt per device
	assign irq_o[0] = tmr_csr_q[`XM23_CSR_DBA] & tmr_csr_q[`XM23_CSR_IE];
	assign irq_o[1] = tl_csr_q[`XM23_CSR_DBA] & tl_csr_q[`XM23_CSR_IE];
	assign irq_o[2] = pb_csr_q[`XM23_CSR_DBA] & pb_csr_q[`XM23_CSR_IE];

endmodule

/* xm23_dev_pkg.sv */
package xm23_dev_pkg;

	typedef logic [7:0] dev_byte_t;	// One device register byte
	typedef logic [3:0] dev_addr_t;	// Byte address inside the device region
	typedef logic [3:0] dev_nib_t;	// CSR status field

	// Event and status from a device back to the register block
	typedef struct packed {
		logic     evt;	// One-cycle strobe, sets DBA
		dev_nib_t status;	// Lands in CSR bits 7:4
	} dev_evt_t;

	// Traffic-light sequencer phases
	typedef enum logic [2:0] {
		TL_OFF   = 3'd0,
		TL_GREEN = 3'd1,
		TL_AMBER = 3'd2,
		TL_RED   = 3'd3,
		TL_WALK  = 3'd4	// Red with the walk lamp on
	} tl_state_t;

	// Lamp outputs, bit 3 walk, bit 2 red, bit 1 amber, bit 0 green
	typedef logic [3:0] lights_t;

endpackage

/* xm23_dev_defines.svh */
`ifndef XM23_DEV_DEFINES_SVH
`define XM23_DEV_DEFINES_SVH

// Device region byte addresses, same layout as the CPU memory map
`define XM23_TMR_CSR	4'h0
`define XM23_TMR_DATA	4'h1
`define XM23_TL_CSR	4'h6
`define XM23_TL_DATA	4'h7
`define XM23_PB_CSR	4'h8
`define XM23_PB_DATA	4'h9

// CSR bit positions shared by every device
`define XM23_CSR_EN	0	// Device enable
`define XM23_CSR_IE	1	// Interrupt enable
`define XM23_CSR_DBA	2	// Data available
`define XM23_CSR_OF	3	// Overflow

// Device timing
`define XM23_TMR_PRESCALE	8	// Clocks per timer tick
`define XM23_TL_AMBER_TICKS	2	// Amber phase length in ticks
`define XM23_PB_DEBOUNCE	16	// Clocks of stable input before a change is taken

`endif
